// ==== logic/ifu_defines.svh ====
// Sizing macros for the instruction fetch unit, included by every RTL file that needs them
`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// --------------------
// Instruction queue
// --------------------

// Depth in halfwords
`define IFU_Q_SIZE_HALF 4

// Read/write pointer, one wrap bit above the slot index
`define IFU_Q_PTR_W ($clog2(`IFU_Q_SIZE_HALF) + 1)

// Free space counts in halfwords and in words
`define IFU_Q_FREE_H_W ($clog2(`IFU_Q_SIZE_HALF + 1))
`define IFU_Q_FREE_W_W ($clog2((`IFU_Q_SIZE_HALF / 2) + 1))

// --------------------
// Memory side
// --------------------

`define IFU_TXN_CNT_W 3   // Up to 7 requests in flight
`define IFU_XLEN 32       // Address and instruction width

`endif

// ==== logic/ifu_mem_pkg.sv ====
// Instruction memory side types, imported by the fetch control logic and the top level
`default_nettype none

`include "ifu_defines.svh"

package ifu_mem_pkg;

    // Response code driven by the instruction memory
    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,   // No response this cycle
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10    // Access fault
    } mem_resp_t;

    // Word address, byte offset dropped
    typedef logic [`IFU_XLEN-3:0] word_addr_t;

    // Request engine state
    typedef enum logic {
        FETCH_IDLE = 1'b0,
        FETCH_RUN  = 1'b1
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== logic/ifu_instr_pkg.sv ====
// Instruction side types shared by the alignment logic, the halfword queue and the top level
`default_nettype none

package ifu_instr_pkg;

    // --------------------
    // Queue access kinds
    // --------------------

    typedef enum logic [1:0] {
        WR_NONE = 2'h0,
        WR_FULL = 2'h1,   // Both halves of the response word
        WR_HI   = 2'h2    // Upper half only
    } q_wr_kind_t;

    typedef enum logic [1:0] {
        RD_NONE = 2'h0,
        RD_HALF = 2'h1,
        RD_WORD = 2'h2
    } q_rd_kind_t;

    // --------------------
    // Response word layout
    // --------------------

    // Named upper half first, then lower half
    typedef enum logic [2:0] {
        RDATA_NONE          = 3'h0,
        RDATA_RVI           = 3'h1,   // One aligned RVI
        RDATA_RVC_RVC       = 3'h2,
        RDATA_RVI_LO_RVC    = 3'h3,   // RVI continues into the next word
        RDATA_RVC_RVI_HI    = 3'h4,   // Low half closes the previous RVI
        RDATA_RVI_LO_RVI_HI = 3'h5,
        RDATA_RVC_NV        = 3'h6,   // Low half skipped after unaligned redirect
        RDATA_RVI_LO_NV     = 3'h7
    } rdata_class_t;

endpackage

`default_nettype wire

// ==== logic/ifu_fetch_ctrl.sv ====
// Fetch request engine of the IFU; drives memory requests and tracks pending and discarded replies
`default_nettype none
`timescale 1ns/10ps

`include "ifu_defines.svh"

module ifu_fetch_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          new_pc_req,
    input  wire logic [`IFU_XLEN-1:0]          new_pc,
    input  wire logic                          stop_fetch,
    input  wire logic                          imem_req_ack,
    input  wire ifu_mem_pkg::mem_resp_t        imem_resp,
    input  wire logic [`IFU_Q_FREE_W_W-1:0]    q_free_words_next,
    output logic                               imem_req,
    output logic [`IFU_XLEN-1:0]               imem_addr,
    output logic                               imem_txns_pending,
    output logic                               resp_keep,
    output logic                               resp_err_kept,
    output logic                               new_pc_unaligned_req
);

    import ifu_mem_pkg::*;

    fetch_state_t               state;
    fetch_state_t               state_next;
    word_addr_t                 addr_r;        // Next word to request
    word_addr_t                 addr_base;
    logic [`IFU_TXN_CNT_W-1:0]  pending;       // Accepted, not yet answered
    logic [`IFU_TXN_CNT_W-1:0]  pending_next;
    logic [`IFU_TXN_CNT_W-1:0]  discard_cnt;   // Replies still to drop
    logic [`IFU_TXN_CNT_W-1:0]  vd_pending;
    logic                       resp_any;
    logic                       discard;
    logic                       req_fire;
    logic                       txn_full;

    // --------------------
    // Response tracking
    // --------------------

    assign resp_any      = (imem_resp == MEM_RESP_RDY_OK) | (imem_resp == MEM_RESP_RDY_ER);
    assign discard       = |discard_cnt;
    assign resp_keep     = resp_any & ~discard;
    assign resp_err_kept = (imem_resp == MEM_RESP_RDY_ER) & ~discard;

    assign req_fire     = imem_req & imem_req_ack;
    assign pending_next = pending + `IFU_TXN_CNT_W'(req_fire) - `IFU_TXN_CNT_W'(resp_any);
    assign vd_pending   = pending - discard_cnt;
    assign txn_full     = (&pending) & ~resp_any;   // A retiring reply frees a slot

    // --------------------
    // Request
    // --------------------

    // Steady fetch only while every live reply has room in the queue
    assign imem_req = ~stop_fetch & ~txn_full &
                      (new_pc_req |
                       ((state == FETCH_RUN) & ~resp_err_kept &
                        (`IFU_TXN_CNT_W'(q_free_words_next) > vd_pending)));

    assign addr_base            = new_pc_req ? new_pc[`IFU_XLEN-1:2] : addr_r;
    assign imem_addr            = {addr_base, 2'b00};
    assign new_pc_unaligned_req = new_pc_req & new_pc[1];
    assign imem_txns_pending    = |pending;

    always_comb begin
        state_next = state;
        if (stop_fetch) begin
            state_next = FETCH_IDLE;
        end else if (new_pc_req) begin
            state_next = FETCH_RUN;
        end else if (resp_err_kept) begin
            state_next = FETCH_IDLE;   // Halt until the next redirect
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FETCH_IDLE;
            addr_r      <= '0;
            pending     <= '0;
            discard_cnt <= '0;
        end else begin
            state   <= state_next;
            pending <= pending_next;
            if (req_fire) begin
                addr_r <= addr_base + 1'b1;
            end else if (new_pc_req) begin
                addr_r <= addr_base;
            end
            if (new_pc_req) begin
                discard_cnt <= pending - `IFU_TXN_CNT_W'(resp_any);   // Old ones in flight
            end else if (resp_err_kept) begin
                discard_cnt <= pending_next;
            end else if (resp_any && discard) begin
                discard_cnt <= discard_cnt - 1'b1;
            end
        end
    end

    // Memory must not answer more requests than it accepted
    a_no_resp_idle: assert property (@(posedge clk) disable iff (!rst_n)
        resp_any |-> (pending != '0));

    // Dropped replies are always a subset of those pending
    a_discard_bound: assert property (@(posedge clk) disable iff (!rst_n)
        discard_cnt <= pending);

endmodule

`default_nettype wire

// ==== logic/ifu_rdata_align.sv ====
// Sorts each kept memory word into RVC and RVI halves and selects which halves go to the queue
`default_nettype none
`timescale 1ns/10ps

`include "ifu_defines.svh"

module ifu_rdata_align (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     new_pc_req,
    input  wire logic                     new_pc_unaligned_req,
    input  wire logic                     resp_keep,
    input  wire logic                     resp_err_kept,
    input  wire logic [`IFU_XLEN-1:0]     imem_rdata,
    output ifu_instr_pkg::q_wr_kind_t     q_wr_kind,
    output logic [`IFU_XLEN-1:0]          wr_data,
    output logic                          wr_err
);

    import ifu_instr_pkg::*;

    logic          unaligned;     // First word after redirect starts at bit 16
    logic          rvi_hi_pend;   // Previous word left an RVI open
    logic          lo_is_rvi;
    logic          hi_is_rvi;
    rdata_class_t  rdata_class;

    assign lo_is_rvi = &imem_rdata[1:0];
    assign hi_is_rvi = &imem_rdata[17:16];

    // --------------------
    // Classification
    // --------------------

    always_comb begin
        rdata_class = RDATA_NONE;
        if (resp_keep && !resp_err_kept) begin
            if (unaligned) begin
                rdata_class = hi_is_rvi ? RDATA_RVI_LO_NV : RDATA_RVC_NV;
            end else if (rvi_hi_pend) begin
                rdata_class = hi_is_rvi ? RDATA_RVI_LO_RVI_HI : RDATA_RVC_RVI_HI;
            end else if (lo_is_rvi) begin
                rdata_class = RDATA_RVI;
            end else begin
                rdata_class = hi_is_rvi ? RDATA_RVI_LO_RVC : RDATA_RVC_RVC;
            end
        end
    end

    always_comb begin
        q_wr_kind = WR_NONE;
        if (resp_err_kept) begin
            q_wr_kind = WR_FULL;   // Error marks both halves
        end else begin
            case (rdata_class)
                RDATA_NONE:      q_wr_kind = WR_NONE;
                RDATA_RVC_NV,
                RDATA_RVI_LO_NV: q_wr_kind = WR_HI;
                default:         q_wr_kind = WR_FULL;
            endcase
        end
    end

    assign wr_data = imem_rdata;
    assign wr_err  = resp_err_kept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unaligned   <= 1'b0;
            rvi_hi_pend <= 1'b0;
        end else if (new_pc_req) begin
            unaligned   <= new_pc_unaligned_req;
            rvi_hi_pend <= 1'b0;
        end else if (resp_keep) begin
            unaligned   <= 1'b0;
            rvi_hi_pend <= (rdata_class == RDATA_RVI_LO_NV) |
                           (rdata_class == RDATA_RVI_LO_RVI_HI) |
                           (rdata_class == RDATA_RVI_LO_RVC);
        end
    end

    a_wr_only_kept: assert property (@(posedge clk) disable iff (!rst_n)
        !resp_keep |-> (q_wr_kind == WR_NONE));

endmodule

`default_nettype wire

// ==== logic/ifu_instr_queue.sv ====
// Four-halfword instruction queue with per-entry fault bits; presents instructions to decode
`default_nettype none
`timescale 1ns/10ps

`include "ifu_defines.svh"

module ifu_instr_queue (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          flush,
    input  wire ifu_instr_pkg::q_wr_kind_t     q_wr_kind,
    input  wire logic [`IFU_XLEN-1:0]          wr_data,
    input  wire logic                          wr_err,
    input  wire logic                          dpu_rdy,
    output logic [`IFU_Q_FREE_W_W-1:0]         q_free_words_next,
    output logic [1:0]                         dpu_vd,
    output logic [`IFU_XLEN-1:0]               dpu_instr,
    output logic                               dpu_imem_err
);

    import ifu_instr_pkg::*;

    localparam int ADR_W = `IFU_Q_PTR_W - 1;

    logic [15:0]                q_data [`IFU_Q_SIZE_HALF];
    logic                       q_err  [`IFU_Q_SIZE_HALF];
    logic [`IFU_Q_PTR_W-1:0]    rptr;
    logic [`IFU_Q_PTR_W-1:0]    wptr;
    logic [`IFU_Q_PTR_W-1:0]    rptr_next;
    logic [`IFU_Q_PTR_W-1:0]    wr_cnt;
    logic [`IFU_Q_PTR_W-1:0]    occupied;
    logic [`IFU_Q_FREE_H_W-1:0] free_h_next;
    logic [ADR_W-1:0]           wadr;
    logic [ADR_W-1:0]           radr_next;
    logic [15:0]                head;
    logic [15:0]                next;
    logic                       err_head;
    logic                       err_next;
    logic                       head_rvi;
    logic                       next_rvc;
    q_rd_kind_t                 rd_kind;

    assign occupied  = wptr - rptr;
    assign wadr      = wptr[ADR_W-1:0];
    assign radr_next = rptr[ADR_W-1:0] + 1'b1;
    assign head      = q_data[rptr[ADR_W-1:0]];
    assign next      = q_data[radr_next];
    assign err_head  = q_err[rptr[ADR_W-1:0]];
    assign err_next  = q_err[radr_next];
    assign head_rvi  = &head[1:0];
    assign next_rvc  = ~(&next[1:0]);

    // --------------------
    // Decode side
    // --------------------

    always_comb begin
        dpu_vd       = 2'b00;
        dpu_imem_err = 1'b0;
        if (occupied == `IFU_Q_PTR_W'(1)) begin
            dpu_vd[0]    = ~head_rvi | err_head;   // Lone RVI half must wait
            dpu_imem_err = err_head;
        end else if (occupied != '0) begin
            dpu_vd       = {~head_rvi & next_rvc & ~err_head & ~err_next, 1'b1};
            dpu_imem_err = err_head | (head_rvi & err_next);
        end
    end

    assign dpu_instr = (head_rvi | dpu_vd[1]) ? {next, head} : {16'h0, head};

    always_comb begin
        rd_kind = RD_NONE;
        if (dpu_vd[0] && dpu_rdy) begin
            rd_kind = (err_head | (~head_rvi & ~dpu_vd[1])) ? RD_HALF : RD_WORD;
        end
    end

    // --------------------
    // Pointers and storage
    // --------------------

    assign rptr_next = rptr + ((rd_kind == RD_WORD) ? `IFU_Q_PTR_W'(2) :
                               (rd_kind == RD_HALF) ? `IFU_Q_PTR_W'(1) : '0);
    assign wr_cnt    = (q_wr_kind == WR_FULL) ? `IFU_Q_PTR_W'(2) :
                       (q_wr_kind == WR_HI)   ? `IFU_Q_PTR_W'(1) : '0;

    assign free_h_next = flush ? `IFU_Q_FREE_H_W'(`IFU_Q_SIZE_HALF) :
                         `IFU_Q_FREE_H_W'(`IFU_Q_SIZE_HALF - (wptr - rptr_next));
    assign q_free_words_next = `IFU_Q_FREE_W_W'(free_h_next >> 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr <= '0;
            wptr <= '0;
        end else if (flush) begin
            rptr <= '0;
            wptr <= '0;
        end else begin
            rptr <= rptr_next;
            wptr <= wptr + wr_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (q_wr_kind == WR_FULL) begin
            q_data[wadr]        <= wr_data[15:0];
            q_err[wadr]         <= wr_err;
            q_data[wadr + 1'b1] <= wr_data[31:16];
            q_err[wadr + 1'b1]  <= wr_err;
        end else if (q_wr_kind == WR_HI) begin
            q_data[wadr] <= wr_data[31:16];
            q_err[wadr]  <= wr_err;
        end
    end

    // Request throttling upstream must leave room for every reply
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || flush)
        `IFU_Q_FREE_H_W'(wr_cnt) <= free_h_next);

endmodule

`default_nettype wire

// ==== logic/ifu_top.sv ====
// IFU top level; joins fetch control, word alignment and the queue to memory and decode ports
`default_nettype none
`timescale 1ns/10ps

`include "ifu_defines.svh"

module ifu_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    // Instruction memory
    input  wire logic                      imem_req_ack,
    output logic                           imem_req,
    output logic [`IFU_XLEN-1:0]           imem_addr,
    input  wire logic [`IFU_XLEN-1:0]      imem_rdata,
    input  wire ifu_mem_pkg::mem_resp_t    imem_resp,
    // Redirect and stop
    input  wire logic                      new_pc_req,
    input  wire logic [`IFU_XLEN-1:0]      new_pc,
    input  wire logic                      stop_fetch,
    output logic                           imem_txns_pending,
    // Decode
    input  wire logic                      dpu_rdy,
    output logic [`IFU_XLEN-1:0]           dpu_instr,
    output logic                           dpu_imem_err,
    output logic [1:0]                     dpu_vd
);

    import ifu_instr_pkg::*;

    logic                        resp_keep;
    logic                        resp_err_kept;
    logic                        new_pc_unaligned_req;
    logic [`IFU_Q_FREE_W_W-1:0]  q_free_words_next;
    q_wr_kind_t                  q_wr_kind;
    logic [`IFU_XLEN-1:0]        wr_data;
    logic                        wr_err;
    logic                        flush;

    assign flush = new_pc_req | stop_fetch;   // Queue drops everything on either

    ifu_fetch_ctrl u_fetch_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .new_pc_req           (new_pc_req),
        .new_pc               (new_pc),
        .stop_fetch           (stop_fetch),
        .imem_req_ack         (imem_req_ack),
        .imem_resp            (imem_resp),
        .q_free_words_next    (q_free_words_next),
        .imem_req             (imem_req),
        .imem_addr            (imem_addr),
        .imem_txns_pending    (imem_txns_pending),
        .resp_keep            (resp_keep),
        .resp_err_kept        (resp_err_kept),
        .new_pc_unaligned_req (new_pc_unaligned_req)
    );

    ifu_rdata_align u_rdata_align (
        .clk                  (clk),
        .rst_n                (rst_n),
        .new_pc_req           (new_pc_req),
        .new_pc_unaligned_req (new_pc_unaligned_req),
        .resp_keep            (resp_keep),
        .resp_err_kept        (resp_err_kept),
        .imem_rdata           (imem_rdata),
        .q_wr_kind            (q_wr_kind),
        .wr_data              (wr_data),
        .wr_err               (wr_err)
    );

    ifu_instr_queue u_instr_queue (
        .clk               (clk),
        .rst_n             (rst_n),
        .flush             (flush),
        .q_wr_kind         (q_wr_kind),
        .wr_data           (wr_data),
        .wr_err            (wr_err),
        .dpu_rdy           (dpu_rdy),
        .q_free_words_next (q_free_words_next),
        .dpu_vd            (dpu_vd),
        .dpu_instr         (dpu_instr),
        .dpu_imem_err      (dpu_imem_err)
    );

endmodule

`default_nettype wire

// ==== dv/ifu_mem_model.sv ====
// Instruction memory model for the IFU testbench; answers word reads in order with random ack and latency
`default_nettype none
`timescale 1ns/10ps

`include "ifu_defines.svh"

module ifu_mem_model #(
    parameter int SEED = 1
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  req,
    input  wire logic [`IFU_XLEN-1:0]  addr,
    output logic                       req_ack,
    output ifu_mem_pkg::mem_resp_t     resp,
    output logic [`IFU_XLEN-1:0]       rdata,
    output int                         outstanding
);

    import ifu_mem_pkg::*;

    logic [`IFU_XLEN-1:0] addr_q [$];   // Accepted, not yet answered
    int                   due_q  [$];   // Earliest reply cycle per entry
    int                   cycle;
    int                   seed;
    int                   lat;
    logic [`IFU_XLEN-1:0] head_addr;

    // Halfword image at byte address h
    function automatic logic [15:0] image_half(input logic [`IFU_XLEN-1:0] h);
        return {h[13:1], 1'b0, (h[2] ^ h[4]) ? 2'b11 : 2'b01};
    endfunction

    initial begin
        seed        = SEED;
        cycle       = 0;
        outstanding = 0;
        req_ack     = 1'b0;
        resp        = MEM_RESP_IDLE;
        rdata       = '0;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            addr_q.delete();
            due_q.delete();
        end else begin
            if (resp != MEM_RESP_IDLE) begin   // Last cycle's reply retires
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            if (req && req_ack) begin
                lat = 1 + ($random(seed) & 3);   // 1 to 4 cycles
                addr_q.push_back(addr);
                due_q.push_back(cycle - 1 + lat);
            end
        end
        outstanding = addr_q.size();
        #1;
        req_ack <= rst_n && (($random(seed) & 3) != 0);
        if (addr_q.size() != 0 && due_q[0] <= cycle) begin
            head_addr = addr_q[0];
            resp  <= (&head_addr[13:10]) ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;   // Word addr 11..8
            rdata <= {image_half(head_addr + 2), image_half(head_addr)};
        end else begin
            resp  <= MEM_RESP_IDLE;
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_ifu.sv ====
// IFU testbench; drives redirects, stalls, faults and stops while assertions check the decode stream
`default_nettype none
`timescale 1ns/10ps

`include "ifu_defines.svh"

module tb_ifu;

    import ifu_mem_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int RAND_SEED      = 58668;
    localparam int NUM_TESTS      = 7;
    localparam int INSTR_PER_TEST = 24;
    localparam int STOP_TEST      = 3;
    localparam int MAX_PENDING    = (1 << `IFU_TXN_CNT_W) - 1;
    localparam int WATCHDOG_NS    = NUM_TESTS * INSTR_PER_TEST * 40 * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  imem_req_ack;
    logic                  imem_req;
    logic [`IFU_XLEN-1:0]  imem_addr;
    logic [`IFU_XLEN-1:0]  imem_rdata;
    mem_resp_t             imem_resp;
    logic                  new_pc_req;
    logic [`IFU_XLEN-1:0]  new_pc;
    logic                  stop_fetch;
    logic                  imem_txns_pending;
    logic                  dpu_rdy;
    logic [`IFU_XLEN-1:0]  dpu_instr;
    logic                  dpu_imem_err;
    logic [1:0]            dpu_vd;
    int                    outstanding;

    int                    seed;
    int                    errors;
    int                    items;
    int                    test_items;
    logic                  test_err;
    logic                  rdy_en;
    logic [`IFU_XLEN-1:0]  ref_pc;      // Reference PC of the next item
    logic                  checking;
    logic                  started;
    logic                  err_halt;
    logic                  take;
    logic [15:0]           exp_lo;
    logic [15:0]           exp_hi;
    logic                  exp_rvi;
    logic [`IFU_XLEN-1:0]  held_instr;
    logic                  held_pair;

    ifu_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .imem_req_ack      (imem_req_ack),
        .imem_req          (imem_req),
        .imem_addr         (imem_addr),
        .imem_rdata        (imem_rdata),
        .imem_resp         (imem_resp),
        .new_pc_req        (new_pc_req),
        .new_pc            (new_pc),
        .stop_fetch        (stop_fetch),
        .imem_txns_pending (imem_txns_pending),
        .dpu_rdy           (dpu_rdy),
        .dpu_instr         (dpu_instr),
        .dpu_imem_err      (dpu_imem_err),
        .dpu_vd            (dpu_vd)
    );

    ifu_mem_model #(.SEED(RAND_SEED)) mem0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (imem_req),
        .addr        (imem_addr),
        .req_ack     (imem_req_ack),
        .resp        (imem_resp),
        .rdata       (imem_rdata),
        .outstanding (outstanding)
    );

    // --------------------
    // Reference model
    // --------------------

    function automatic logic [15:0] image_half(input logic [`IFU_XLEN-1:0] h);
        return {h[13:1], 1'b0, (h[2] ^ h[4]) ? 2'b11 : 2'b01};
    endfunction

    function automatic logic in_fault(input logic [`IFU_XLEN-1:0] a);
        return &a[13:10];   // Word address bits 11..8
    endfunction

    function automatic logic [`IFU_XLEN-1:0] start_pc(input int idx);
        case (idx)
            0:       return 32'h0000_0100;
            1:       return 32'h0000_0202;   // Unaligned start
            2:       return 32'h0000_1006;
            3:       return 32'h0000_2010;
            4:       return 32'h0000_3bf8;   // Runs into the fault region
            5:       return 32'h0000_0a0e;
            default: return 32'h0000_0512;
        endcase
    endfunction

    assign take    = dpu_vd[0] && dpu_rdy && checking;
    assign exp_lo  = image_half(ref_pc);
    assign exp_hi  = image_half(ref_pc + 2);
    assign exp_rvi = &exp_lo[1:0];

    always @(posedge clk) begin
        held_instr <= dpu_instr;
        held_pair  <= dpu_vd[1];
        if (!rst_n) begin
            ref_pc     <= '0;
            checking   <= 1'b0;
            started    <= 1'b0;
            err_halt   <= 1'b0;
            test_err   <= 1'b0;
            test_items <= 0;
            items      <= 0;
        end else if (new_pc_req) begin
            ref_pc     <= new_pc;
            checking   <= !stop_fetch;
            started    <= 1'b1;
            err_halt   <= 1'b0;
            test_err   <= 1'b0;
            test_items <= 0;
        end else if (stop_fetch) begin
            checking <= 1'b0;
        end else if (take) begin
            items      <= items + 1;
            test_items <= test_items + 1;
            if (dpu_imem_err) begin
                checking <= 1'b0;   // Nothing valid follows a fault
                err_halt <= 1'b1;
                test_err <= 1'b1;
            end else if (exp_rvi || dpu_vd[1]) begin
                ref_pc <= ref_pc + 4;
            end else begin
                ref_pc <= ref_pc + 2;
            end
        end
    end

    // --------------------
    // Checks
    // --------------------

    a_idle_before_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (!started && !new_pc_req) |-> (!imem_req && dpu_vd == 2'b00 && !imem_txns_pending))
        else begin
            errors = errors + 1;
            $display("error at %0t: IFU active before the first redirect", $time);
        end

    a_item_low: assert property (@(posedge clk) disable iff (!rst_n)
        (take && !dpu_imem_err) |-> dpu_instr[15:0] == exp_lo)
        else begin
            errors = errors + 1;
            $display("error at %0t: dpu_instr[15:0] expected %h got %h",
                     $time, $sampled(exp_lo), $sampled(dpu_instr[15:0]));
        end

    a_item_high: assert property (@(posedge clk) disable iff (!rst_n)
        (take && !dpu_imem_err && (exp_rvi || dpu_vd[1])) |-> dpu_instr[31:16] == exp_hi)
        else begin
            errors = errors + 1;
            $display("error at %0t: dpu_instr[31:16] expected %h got %h",
                     $time, $sampled(exp_hi), $sampled(dpu_instr[31:16]));
        end

    a_pair_rvc: assert property (@(posedge clk) disable iff (!rst_n)
        (take && !dpu_imem_err && dpu_vd[1]) |-> (!exp_rvi && !(&exp_hi[1:0])))
        else begin
            errors = errors + 1;
            $display("error at %0t: pair flagged at pc %h, image has no RVC pair there",
                     $time, $sampled(ref_pc));
        end

    // Stalled output must not move
    a_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (dpu_vd[0] && !dpu_rdy && !new_pc_req && !stop_fetch) |=> dpu_vd[0])
        else begin
            errors = errors + 1;
            $display("error at %0t: dpu_vd[0] expected 1 got %b", $time, $sampled(dpu_vd[0]));
        end

    a_hold_instr: assert property (@(posedge clk) disable iff (!rst_n)
        (dpu_vd[0] && !dpu_rdy && !new_pc_req && !stop_fetch) |=>
        (dpu_instr[15:0] == held_instr[15:0] &&
         (!(held_pair || &held_instr[1:0]) || dpu_instr[31:16] == held_instr[31:16])))
        else begin
            errors = errors + 1;
            $display("error at %0t: dpu_instr expected %h got %h",
                     $time, $sampled(held_instr), $sampled(dpu_instr));
        end

    a_mem_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= MAX_PENDING)
        else begin
            errors = errors + 1;
            $display("error at %0t: outstanding expected at most %0d got %0d",
                     $time, MAX_PENDING, $sampled(outstanding));
        end

    // Pending flag follows the memory's own count of open reads
    a_txns_pending: assert property (@(posedge clk) disable iff (!rst_n)
        imem_txns_pending == (outstanding != 0))
        else begin
            errors = errors + 1;
            $display("error at %0t: imem_txns_pending expected %b got %b",
                     $time, $sampled(outstanding != 0), $sampled(imem_txns_pending));
        end

    a_err_in_region: assert property (@(posedge clk) disable iff (!rst_n)
        (take && dpu_imem_err) |-> (in_fault(ref_pc) || (exp_rvi && in_fault(ref_pc + 2))))
        else begin
            errors = errors + 1;
            $display("error at %0t: access fault reported at pc %h outside the fault region",
                     $time, $sampled(ref_pc));
        end

    a_halt_after_err: assert property (@(posedge clk) disable iff (!rst_n)
        (err_halt && !new_pc_req) |-> !(imem_req && imem_req_ack))
        else begin
            errors = errors + 1;
            $display("error at %0t: memory request accepted after an access fault", $time);
        end

    a_stop_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        stop_fetch |-> !imem_req)
        else begin
            errors = errors + 1;
            $display("error at %0t: imem_req expected 0 got 1 during stop", $time);
        end

    a_stop_queue_empty: assert property (@(posedge clk) disable iff (!rst_n)
        stop_fetch |=> dpu_vd == 2'b00)
        else begin
            errors = errors + 1;
            $display("error at %0t: dpu_vd expected 00 got %b", $time, $sampled(dpu_vd));
        end

    // --------------------
    // Stimulus
    // --------------------

    task automatic run_test(input logic [`IFU_XLEN-1:0] pc, input logic with_stop);
        @(posedge clk);
        #1;
        stop_fetch = 1'b0;
        new_pc_req = 1'b1;
        new_pc     = pc;
        @(posedge clk);
        #1;
        new_pc_req = 1'b0;
        while (test_items < INSTR_PER_TEST && !test_err) begin
            @(posedge clk);
            #1;
        end
        if (test_err) begin
            repeat (8) @(posedge clk);   // Fetch should stay halted here
        end
        if (with_stop) begin
            stop_fetch = 1'b1;
            do begin
                @(posedge clk);
                #1;
            end while (imem_txns_pending);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            dpu_rdy = rdy_en && (($random(seed) & 3) != 0);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        seed       = RAND_SEED;
        errors     = 0;
        rst_n      = 1'b0;
        new_pc_req = 1'b0;
        new_pc     = '0;
        stop_fetch = 1'b0;
        dpu_rdy    = 1'b0;
        rdy_en     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (5) @(posedge clk);   // Quiet window before the first redirect
        #1;
        rdy_en = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(start_pc(t), t == STOP_TEST);
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d failed checks, %0d items consumed over %0d tests",
                 errors, items, NUM_TESTS);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/ifu_mem_pkg.sv
logic/ifu_instr_pkg.sv
logic/ifu_fetch_ctrl.sv
logic/ifu_rdata_align.sv
logic/ifu_instr_queue.sv
logic/ifu_top.sv
dv/ifu_mem_model.sv
dv/tb_ifu.sv

// ==== Makefile ====
# Verilator flow for the IFU testbench
# Any variable can be overridden, e.g. make sim LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

# The run passes only if the log holds the pass line
sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
